/* design/vwrite_pkg.sv */
`default_nettype none

package vwrite_pkg;

   localparam int unsigned DATA_W     = 32;
   localparam int unsigned EXT_ADDR_W = 32;
   localparam int unsigned LEN_W      = 16;
   localparam int unsigned CFG_W      = 16;
   localparam int unsigned PER_W      = 12;
   localparam int unsigned DELAY_W    = 8;

   // store pattern, two loop levels
   typedef struct packed {
      logic [CFG_W-1:0]   start;
      logic [CFG_W-1:0]   incr;
      logic [PER_W-1:0]   duty;
      logic [PER_W-1:0]   per;
      logic [CFG_W-1:0]   iter;
      logic [CFG_W-1:0]   shift;
      logic [CFG_W-1:0]   per2;
      logic [CFG_W-1:0]   incr2;
      logic [DELAY_W-1:0] delay;
   } store_cfg_t;

   // length in bytes, multiple of 4
   typedef struct packed {
      logic                  enabled;
      logic [EXT_ADDR_W-1:0] ext_addr;
      logic [CFG_W-1:0]      amount_minus_one;
      logic [LEN_W-1:0]      length;
   } xfer_cfg_t;

   typedef struct packed {
      logic                  valid;
      logic [EXT_ADDR_W-1:0] addr;
      logic [LEN_W-1:0]      len;
      logic [DATA_W-1:0]     wdata;
      logic [DATA_W/8-1:0]   wstrb;
   } databus_req_t;

   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_BURST,
      SEQ_DONE
   } seq_state_t;

endpackage

`default_nettype wire

/* design/store_addr_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module store_addr_gen #(
   parameter int ADDR_W = 8
) (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire logic                   run_i,
   input  wire vwrite_pkg::store_cfg_t cfg_i,
   input  wire logic                   bank_i,
   input  wire logic                   bank_en_i,
   output logic                        we_o,
   output logic [ADDR_W-1:0]           waddr_o,
   output logic                        done_o
);

   logic                               active_q;
   logic [vwrite_pkg::DELAY_W-1:0]     dly_q;
   logic [vwrite_pkg::PER_W-1:0]       cyc_q;
   logic [vwrite_pkg::CFG_W-1:0]       pcnt_q;
   logic [vwrite_pkg::CFG_W-1:0]       ocnt_q;
   logic [ADDR_W-1:0]                  addr_q;
   logic [ADDR_W-1:0]                  obase_q;

   logic                               slot;
   logic                               last_cyc;
   logic                               last_per;
   logic                               last_outer;
   logic                               fin;
   logic [ADDR_W-1:0]                  addr_step;

   // a slot is any cycle past the start delay
   assign slot       = active_q && (dly_q == '0);
   assign we_o       = slot && (cyc_q < cfg_i.duty);
   assign last_cyc   = (cyc_q == cfg_i.per - 1'b1);
   assign last_per   = (pcnt_q == cfg_i.iter - 1'b1);
   assign last_outer = (ocnt_q == cfg_i.per2 - 1'b1);

   // stop right after the last store of the last period
   assign fin = slot && last_per && last_outer &&
                (last_cyc || (we_o && (cyc_q == cfg_i.duty - 1'b1)));

   assign addr_step = we_o ? addr_q + cfg_i.incr[ADDR_W-1:0] : addr_q;
   assign waddr_o   = bank_en_i ? {bank_i, addr_q[ADDR_W-2:0]} : addr_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active_q <= 1'b0;
         dly_q    <= '0;
         cyc_q    <= '0;
         pcnt_q   <= '0;
         ocnt_q   <= '0;
         done_o   <= 1'b1;
      end else if (run_i) begin
         active_q <= (cfg_i.iter != '0) && (cfg_i.per2 != '0);
         dly_q    <= cfg_i.delay;
         cyc_q    <= '0;
         pcnt_q   <= '0;
         ocnt_q   <= '0;
         done_o   <= 1'b0;
      end else begin
         done_o <= !active_q;
         if (dly_q != '0) begin
            dly_q <= dly_q - 1'b1;
         end else if (active_q) begin
            if (fin) begin
               active_q <= 1'b0;
            end
            if (last_cyc) begin
               cyc_q <= '0;
               if (last_per) begin
                  pcnt_q <= '0;
                  ocnt_q <= ocnt_q + 1'b1;
               end else begin
                  pcnt_q <= pcnt_q + 1'b1;
               end
            end else begin
               cyc_q <= cyc_q + 1'b1;
            end
         end
      end
   end

   // running address, outer base steps by incr2
   always_ff @(posedge clk) begin
      if (run_i) begin
         addr_q  <= cfg_i.start[ADDR_W-1:0];
         obase_q <= cfg_i.start[ADDR_W-1:0];
      end else if (slot) begin
         if (last_cyc && last_per) begin
            addr_q  <= obase_q + cfg_i.incr2[ADDR_W-1:0];
            obase_q <= obase_q + cfg_i.incr2[ADDR_W-1:0];
         end else if (last_cyc) begin
            addr_q <= addr_step + cfg_i.shift[ADDR_W-1:0];
         end else begin
            addr_q <= addr_step;
         end
      end
   end

endmodule

`default_nettype wire

/* design/burst_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module burst_sequencer (
   input  wire logic                          clk,
   input  wire logic                          rst,
   input  wire logic                          run_i,
   input  wire vwrite_pkg::xfer_cfg_t         cfg_i,
   input  wire logic                          data_valid_i,
   input  wire logic [vwrite_pkg::DATA_W-1:0] data_i,
   input  wire logic                          databus_ready_i,
   input  wire logic                          databus_last_i,
   output vwrite_pkg::databus_req_t           databus_req_o,
   output logic                               pop_o,
   output logic                               done_o
);

   // byte count of up to 2^CFG_W words
   localparam int unsigned REM_W = vwrite_pkg::CFG_W + 3;

   vwrite_pkg::seq_state_t                    state_q;
   logic [REM_W-1:0]                          rem_q;
   logic [vwrite_pkg::EXT_ADDR_W-1:0]         addr_q;

   logic [REM_W-1:0]                          total;
   logic [vwrite_pkg::LEN_W-1:0]              len;
   logic                                      beat;
   logic                                      final_beat;

   assign total = (REM_W'(cfg_i.amount_minus_one) + 1'b1) << 2;

   // burst length is the smaller of the limit and what is left
   assign len = (rem_q > REM_W'(cfg_i.length)) ? cfg_i.length : rem_q[vwrite_pkg::LEN_W-1:0];

   always_comb begin
      databus_req_o.valid = (state_q == vwrite_pkg::SEQ_BURST) && data_valid_i;
      databus_req_o.addr  = addr_q;
      databus_req_o.len   = len;
      databus_req_o.wdata = data_i;
      databus_req_o.wstrb = '1;
   end

   assign beat       = databus_req_o.valid && databus_ready_i;
   assign final_beat = beat && databus_last_i;
   assign pop_o      = beat;
   assign done_o     = (state_q == vwrite_pkg::SEQ_IDLE) || (state_q == vwrite_pkg::SEQ_DONE);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q <= vwrite_pkg::SEQ_IDLE;
         rem_q   <= '0;
         addr_q  <= '0;
      end else if (run_i) begin
         state_q <= cfg_i.enabled ? vwrite_pkg::SEQ_BURST : vwrite_pkg::SEQ_DONE;
         rem_q   <= total;
         addr_q  <= cfg_i.ext_addr;
      end else begin
         case (state_q)
            vwrite_pkg::SEQ_BURST: begin
               // next burst starts where this one ended
               if (final_beat) begin
                  rem_q  <= rem_q - REM_W'(len);
                  addr_q <= addr_q + vwrite_pkg::EXT_ADDR_W'(len);
                  if (rem_q == REM_W'(len)) begin
                     state_q <= vwrite_pkg::SEQ_DONE;
                  end
               end
            end
            default: begin
               state_q <= state_q;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* design/buffer_reader.sv */
`timescale 1ns/1ns
`default_nettype none

module buffer_reader #(
   parameter int ADDR_W = 8
) (
   input  wire logic                          clk,
   input  wire logic                          rst,
   input  wire logic                          run_i,
   input  wire logic [ADDR_W-1:0]             base_i,
   input  wire logic                          pop_i,
   output logic                               valid_o,
   output logic [vwrite_pkg::DATA_W-1:0]      data_o,
   output logic                               mem_re_o,
   output logic [ADDR_W-1:0]                  mem_raddr_o,
   input  wire logic [vwrite_pkg::DATA_W-1:0] mem_rdata_i
);

   logic                                      en_q;
   logic                                      inflight_q;
   logic                                      hold_valid_q;
   logic [ADDR_W-1:0]                         addr_q;
   logic [vwrite_pkg::DATA_W-1:0]             hold_q;

   logic                                      hold_free;
   logic                                      load;

   // holding register has room this cycle
   assign hold_free = !hold_valid_q || pop_i;
   assign load      = inflight_q && hold_free;

   // memory keeps rdata while re is low, so a stalled word waits there
   assign mem_re_o    = en_q && hold_free;
   assign mem_raddr_o = addr_q;
   assign valid_o     = hold_valid_q;
   assign data_o      = hold_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         en_q         <= 1'b0;
         inflight_q   <= 1'b0;
         hold_valid_q <= 1'b0;
         addr_q       <= '0;
      end else if (run_i) begin
         en_q         <= 1'b1;
         inflight_q   <= 1'b0;
         hold_valid_q <= 1'b0;
         addr_q       <= base_i;
      end else begin
         if (mem_re_o) begin
            addr_q <= addr_q + 1'b1;
         end
         inflight_q <= mem_re_o || (inflight_q && !load);
         if (load) begin
            hold_valid_q <= 1'b1;
         end else if (pop_i) begin
            hold_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         hold_q <= mem_rdata_i;
      end
   end

endmodule

`default_nettype wire

/* design/wbuffer_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module wbuffer_mem #(
   parameter int ADDR_W = 8
) (
   input  wire logic                          clk,
   input  wire logic                          we_i,
   input  wire logic [ADDR_W-1:0]             waddr_i,
   input  wire logic [vwrite_pkg::DATA_W-1:0] wdata_i,
   input  wire logic                          re_i,
   input  wire logic [ADDR_W-1:0]             raddr_i,
   output logic [vwrite_pkg::DATA_W-1:0]      rdata_o
);

   logic [vwrite_pkg::DATA_W-1:0] mem_q [2**ADDR_W];

   // read before write on a shared address
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem_q[waddr_i] <= wdata_i;
      end
      if (re_i) begin
         rdata_o <= mem_q[raddr_i];
      end
   end

endmodule

`default_nettype wire

/* design/vwrite_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module vwrite_unit #(
   parameter int ADDR_W = 8
) (
   input  wire logic                          clk,
   input  wire logic                          rst,
   input  wire logic                          run_i,
   output logic                               done_o,
   input  wire logic                          ping_pong_i,
   input  wire vwrite_pkg::store_cfg_t        store_cfg_i,
   input  wire vwrite_pkg::xfer_cfg_t         xfer_cfg_i,
   input  wire logic [vwrite_pkg::DATA_W-1:0] in0_i,
   output vwrite_pkg::databus_req_t           databus_req_o,
   input  wire logic                          databus_ready_i,
   input  wire logic                          databus_last_i
);

   logic                          pp_q;
   logic                          pp_en_q;
   logic [ADDR_W-1:0]             read_base;
   logic                          store_we;
   logic [ADDR_W-1:0]             store_addr;
   logic                          store_done;
   logic                          seq_done;
   logic                          rd_valid;
   logic [vwrite_pkg::DATA_W-1:0] rd_data;
   logic                          pop;
   logic                          mem_re;
   logic [ADDR_W-1:0]             mem_raddr;
   logic [vwrite_pkg::DATA_W-1:0] mem_rdata;

   // sampled on run, so this is the inverse of the bank being stored next
   assign read_base = {ping_pong_i & pp_q, {(ADDR_W-1){1'b0}}};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pp_q    <= 1'b0;
         pp_en_q <= 1'b0;
         done_o  <= 1'b1;
      end else if (run_i) begin
         pp_q    <= ping_pong_i & !pp_q;
         pp_en_q <= ping_pong_i;
         done_o  <= 1'b0;
      end else if (store_done && seq_done) begin
         done_o <= 1'b1;
      end
   end

   store_addr_gen #(.ADDR_W(ADDR_W)) u_store (
      .clk       (clk),
      .rst       (rst),
      .run_i     (run_i),
      .cfg_i     (store_cfg_i),
      .bank_i    (pp_q),
      .bank_en_i (pp_en_q),
      .we_o      (store_we),
      .waddr_o   (store_addr),
      .done_o    (store_done)
   );

   wbuffer_mem #(.ADDR_W(ADDR_W)) u_mem (
      .clk     (clk),
      .we_i    (store_we),
      .waddr_i (store_addr),
      .wdata_i (in0_i),
      .re_i    (mem_re),
      .raddr_i (mem_raddr),
      .rdata_o (mem_rdata)
   );

   buffer_reader #(.ADDR_W(ADDR_W)) u_reader (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .base_i      (read_base),
      .pop_i       (pop),
      .valid_o     (rd_valid),
      .data_o      (rd_data),
      .mem_re_o    (mem_re),
      .mem_raddr_o (mem_raddr),
      .mem_rdata_i (mem_rdata)
   );

   burst_sequencer u_seq (
      .clk             (clk),
      .rst             (rst),
      .run_i           (run_i),
      .cfg_i           (xfer_cfg_i),
      .data_valid_i    (rd_valid),
      .data_i          (rd_data),
      .databus_ready_i (databus_ready_i),
      .databus_last_i  (databus_last_i),
      .databus_req_o   (databus_req_o),
      .pop_o           (pop),
      .done_o          (seq_done)
   );

endmodule

`default_nettype wire

/* sim/tb_vwrite_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_vwrite_unit;

   localparam int ADDR_W          = 8;
   localparam int DEPTH           = 2**ADDR_W;
   localparam int NUM_TESTS       = 6;
   localparam int CYCLES_PER_TEST = 4000;

   logic                          clk;
   logic                          rst;
   logic                          run_i;
   logic                          done_o;
   logic                          ping_pong_i;
   vwrite_pkg::store_cfg_t        store_cfg_i;
   vwrite_pkg::xfer_cfg_t         xfer_cfg_i;
   logic [vwrite_pkg::DATA_W-1:0] in0_i;
   vwrite_pkg::databus_req_t      databus_req_o;
   logic                          databus_ready_i;
   logic                          databus_last_i;

   integer                        seed = 58194;
   int                            errors = 0;
   int                            checks = 0;
   int                            cyc = 0;
   logic                          pp_model = 1'b0;
   logic [31:0]                   model [DEPTH];
   logic [31:0]                   exp_q [$];
   int                            seen_len [$];
   int                            seen_addr [$];
   int                            beat_idx = 0;
   int                            burst_beat = 0;
   int                            last_cnt = 0;
   int                            rem = 0;
   int                            lim = 0;
   int                            exp_len = 0;
   logic [31:0]                   exp_addr = '0;
   logic                          stress = 1'b0;
   logic                          stalled = 1'b0;
   logic                          ready_next;
   vwrite_pkg::databus_req_t      held;

   vwrite_unit #(.ADDR_W(ADDR_W)) dut (
      .clk             (clk),
      .rst             (rst),
      .run_i           (run_i),
      .done_o          (done_o),
      .ping_pong_i     (ping_pong_i),
      .store_cfg_i     (store_cfg_i),
      .xfer_cfg_i      (xfer_cfg_i),
      .in0_i           (in0_i),
      .databus_req_o   (databus_req_o),
      .databus_ready_i (databus_ready_i),
      .databus_last_i  (databus_last_i)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // input word equals the number of the edge that writes it
   always @(posedge clk) begin
      cyc   <= cyc + 1;
      in0_i <= cyc + 1;
   end

   task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("mismatch %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic require(input logic cond, input string what);
      checks++;
      assert (cond) else begin
         errors++;
         $display("error: %s", what);
      end
   endtask

   // databus model
   always @(posedge clk) begin
      if (stalled) begin
         require(databus_req_o.valid, "valid dropped before the beat was accepted");
         compare("stalled addr", databus_req_o.addr, held.addr);
         compare("stalled len", databus_req_o.len, held.len);
         compare("stalled wdata", databus_req_o.wdata, held.wdata);
      end
      stalled = databus_req_o.valid && !databus_ready_i;
      held    = databus_req_o;
      if (databus_req_o.valid && databus_ready_i) begin
         require(beat_idx < exp_q.size(), "beat accepted with no word left to send");
         if (beat_idx < exp_q.size()) begin
            compare("wdata", databus_req_o.wdata, exp_q[beat_idx]);
            compare("addr", databus_req_o.addr, exp_addr);
            compare("len", databus_req_o.len, exp_len);
            compare("wstrb", databus_req_o.wstrb, 4'hf);
         end
         beat_idx++;
         burst_beat++;
         if (databus_last_i) begin
            seen_len.push_back(databus_req_o.len);
            seen_addr.push_back(databus_req_o.addr);
            last_cnt++;
            exp_addr   = exp_addr + exp_len;
            rem        = rem - exp_len;
            exp_len    = (rem > lim) ? lim : rem;
            burst_beat = 0;
         end
      end
      ready_next = stress ? (($random(seed) & 7) == 0) : (($random(seed) & 3) != 0);
      databus_ready_i <= ready_next;
      databus_last_i  <= ready_next && (exp_len != 0) && (burst_beat == exp_len / 4 - 1);
   end

   function automatic vwrite_pkg::store_cfg_t make_store(input int start, input int incr,
         input int duty, input int per, input int iter, input int shift, input int per2,
         input int incr2, input int delay);
      vwrite_pkg::store_cfg_t c;
      c.start = start;
      c.incr  = incr;
      c.duty  = duty;
      c.per   = per;
      c.iter  = iter;
      c.shift = shift;
      c.per2  = per2;
      c.incr2 = incr2;
      c.delay = delay;
      return c;
   endfunction

   function automatic vwrite_pkg::xfer_cfg_t make_xfer(input logic en, input int addr,
         input int words, input int len);
      vwrite_pkg::xfer_cfg_t c;
      c.enabled          = en;
      c.ext_addr         = addr;
      c.amount_minus_one = words - 1;
      c.length           = len;
      return c;
   endfunction

   task automatic apply_store(input vwrite_pkg::store_cfg_t sc, input logic pp,
                              input logic bank, input int run_edge);
      int a;
      int wa;
      int t;
      for (int r = 0; r < int'(sc.per2); r++) begin
         for (int p = 0; p < int'(sc.iter); p++) begin
            for (int j = 0; j < int'(sc.duty); j++) begin
               a = int'(sc.start) + r * int'(sc.incr2) + j * int'(sc.incr)
                   + p * (int'(sc.duty) * int'(sc.incr) + int'(sc.shift));
               t = run_edge + 1 + int'(sc.delay) + (r * int'(sc.iter) + p) * int'(sc.per) + j;
               if (pp) begin
                  wa = (bank ? DEPTH / 2 : 0) + (a & (DEPTH / 2 - 1));
               end else begin
                  wa = a & (DEPTH - 1);
               end
               model[wa] = t;
            end
         end
      end
   endtask

   task automatic run_and_wait(input logic pp, input vwrite_pkg::store_cfg_t sc,
                               input vwrite_pkg::xfer_cfg_t xc, input logic slow_bus);
      int base;
      int run_edge;
      int bursts;
      @(negedge clk);
      pp_model = pp ? !pp_model : 1'b0;
      base     = (pp && !pp_model) ? DEPTH / 2 : 0;
      exp_q.delete();
      seen_len.delete();
      seen_addr.delete();
      if (xc.enabled) begin
         for (int i = 0; i <= int'(xc.amount_minus_one); i++) begin
            exp_q.push_back(model[(base + i) % DEPTH]);
         end
      end
      lim        = xc.length;
      rem        = exp_q.size() * 4;
      exp_len    = (rem > lim) ? lim : rem;
      exp_addr   = xc.ext_addr;
      beat_idx   = 0;
      burst_beat = 0;
      last_cnt   = 0;
      stress     = slow_bus;
      @(posedge clk);
      run_edge = cyc + 1;
      ping_pong_i <= pp;
      store_cfg_i <= sc;
      xfer_cfg_i  <= xc;
      run_i       <= 1'b1;
      // stores of this run land after the expected words were taken
      apply_store(sc, pp, pp_model, run_edge);
      @(posedge clk);
      run_i <= 1'b0;
      @(posedge clk);
      require(!done_o, "done_o did not fall after run");
      while (!done_o) @(posedge clk);
      compare("beat count", beat_idx, exp_q.size());
      bursts = (lim == 0) ? 0 : (exp_q.size() * 4 + lim - 1) / lim;
      compare("last count", last_cnt, bursts);
   endtask

   task automatic idle_run();
      require(done_o, "done_o low after reset");
      require(!databus_req_o.valid, "databus valid high after reset");
      run_and_wait(1'b0, make_store(0, 0, 0, 0, 0, 0, 1, 0, 0), make_xfer(0, 0, 1, 4), 1'b0);
      compare("beats in idle run", beat_idx, 0);
   endtask

   task automatic ping_pong_transfer();
      run_and_wait(1'b1, make_store(0, 1, 16, 16, 1, 0, 1, 0, 0), make_xfer(0, 0, 1, 4), 1'b0);
      run_and_wait(1'b1, make_store(0, 1, 20, 20, 1, 0, 1, 0, 0),
                   make_xfer(1, 'h1000, 16, 64), 1'b0);
   endtask

   task automatic burst_split();
      run_and_wait(1'b1, make_store(1, 2, 2, 3, 2, 3, 2, 4, 2),
                   make_xfer(1, 'h2000, 20, 32), 1'b0);
      compare("burst count", seen_len.size(), 3);
      for (int i = 0; i < 3 && i < seen_len.size(); i++) begin
         compare("burst len", seen_len[i], (i == 2) ? 16 : 32);
         compare("burst addr", seen_addr[i], 'h2000 + 32 * i);
      end
   endtask

   // words of the strided run mixed with older ones
   task automatic strided_pattern();
      run_and_wait(1'b1, make_store(0, 1, 24, 24, 1, 0, 1, 0, 5),
                   make_xfer(1, 'h3000, 16, 16), 1'b0);
   endtask

   task automatic back_pressure();
      run_and_wait(1'b1, make_store(0, 0, 0, 0, 0, 0, 1, 0, 0),
                   make_xfer(1, 'h4000, 24, 16), 1'b1);
   endtask

   task automatic flat_buffer();
      run_and_wait(1'b0, make_store(2, 4, 1, 2, 6, 0, 1, 0, 0), make_xfer(0, 0, 1, 4), 1'b0);
      run_and_wait(1'b0, make_store(0, 0, 0, 0, 0, 0, 1, 0, 0),
                   make_xfer(1, 'h5000, 24, 40), 1'b0);
   endtask

   initial begin
      rst             = 1'b1;
      run_i           = 1'b0;
      ping_pong_i     = 1'b0;
      store_cfg_i     = '0;
      xfer_cfg_i      = '0;
      in0_i           = '0;
      databus_ready_i = 1'b0;
      databus_last_i  = 1'b0;
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      idle_run();
      ping_pong_transfer();
      burst_split();
      strided_pattern();
      back_pressure();
      flat_buffer();
      $display("checks: %0d errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   initial begin
      repeat (16 + NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
      errors++;
      $display("timeout: tests still running after %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
      $display("checks: %0d errors: %0d", checks, errors);
      $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

/* vwrite_unit.f */
design/vwrite_pkg.sv
design/store_addr_gen.sv
design/burst_sequencer.sv
design/buffer_reader.sv
design/wbuffer_mem.sv
design/vwrite_unit.sv
sim/tb_vwrite_unit.sv

/* Bender.yml */
package:
  name: vwrite_unit

sources:
  - design/vwrite_pkg.sv
  - design/store_addr_gen.sv
  - design/burst_sequencer.sv
  - design/buffer_reader.sv
  - design/wbuffer_mem.sv
  - design/vwrite_unit.sv
  - target: simulation
    files:
      - sim/tb_vwrite_unit.sv
